// File: logic/core_cfg_pkg.sv
// core sizing constants
// register file sizes, free list and reorder buffer depths, index widths
package core_cfg_pkg;

	// ==========================================================
	// register files
	// ==========================================================
	localparam int AREG_NUM   = 32;	// architectural regs
	localparam int AREG_IDX_W = 5;
	localparam int PREG_NUM   = 64;	// physical regs
	localparam int PREG_IDX_W = 6;	// physical tag width

	// ==========================================================
	// queues
	// ==========================================================
	localparam int FL_DEPTH  = PREG_NUM - AREG_NUM;	// regs not mapped at reset
	localparam int FL_IDX_W  = 5;
	localparam int ROB_DEPTH = 16;
	localparam int ROB_IDX_W = 4;

	// r31 reads as zero, never gets a new tag
	localparam int ZERO_REG = 31;

endpackage : core_cfg_pkg

// File: logic/core_types_pkg.sv
// enumerated types shared across the core
// decoded instruction class and core status
package core_types_pkg;

	// ==========================================================
	// instruction class from the decoder
	// ==========================================================
	// only alu and load write a destination
	typedef enum logic [1:0] {
		CLS_ALU    = 2'd0,
		CLS_LOAD   = 2'd1,
		CLS_STORE  = 2'd2,
		CLS_BRANCH = 2'd3
	} inst_class_e;

	// core status, latched at retirement
	typedef enum logic [1:0] {
		ST_NO_ERROR = 2'd0,
		ST_HALTED   = 2'd1	// a halt has retired
	} core_status_e;

endpackage : core_types_pkg

// File: logic/dispatch_ctrl.sv
// dispatch control
// merges rob, free list and halt stalls into the dispatch strobe
// raises the free list pop for destination-writing instructions
`timescale 1ns/1ps

module dispatch_ctrl (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 inst_vld_i,
	input  core_types_pkg::inst_class_e          inst_class_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  inst_dest_i,
	input  logic                                 inst_halt_i,
	input  logic                                 rob_full_i,
	input  logic                                 free_vld_i,
	input  logic                                 halted_i,
	output logic                                 dispatch_o,
	output logic                                 fl_pop_o,
	output logic                                 stall_o
);
	import core_cfg_pkg::*;
	import core_types_pkg::*;

	logic needs_dest;	// instruction takes a new tag
	logic blocked;
	logic halt_pending_q;	// halt already sent into the rob

	assign needs_dest = ((inst_class_i == CLS_ALU) || (inst_class_i == CLS_LOAD)) &&
		(inst_dest_i != AREG_IDX_W'(ZERO_REG));

	// any one of these holds the instruction at the input
	assign blocked = rob_full_i | (needs_dest & ~free_vld_i) | halt_pending_q | halted_i;

	assign stall_o    = inst_vld_i & blocked;
	assign dispatch_o = inst_vld_i & ~blocked;
	assign fl_pop_o   = dispatch_o & needs_dest;	// also the rename strobe

	// sticky until reset, nothing follows a halt
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			halt_pending_q <= 1'b0;
		end else if (dispatch_o && inst_halt_i) begin
			halt_pending_q <= 1'b1;
		end
	end

	a_no_dispatch_after_halt: assert property (@(posedge clk) disable iff (!rst_n_i)
		(dispatch_o && inst_halt_i) |=> !dispatch_o)
		else $error("dispatch after halt");

endmodule : dispatch_ctrl

// File: logic/map_table.sv
// rename map table
// architectural to physical tag mapping, one ready bit per physical reg
// cdb broadcast sets ready, bypassed to same-cycle lookups
`timescale 1ns/1ps

module map_table (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  ra_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  rb_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  dest_i,
	input  logic                                 rename_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  new_tag_i,
	input  logic                                 cdb_vld_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  cdb_tag_i,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  opa_tag_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  opb_tag_o,
	output logic                                 opa_rdy_o,
	output logic                                 opb_rdy_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  old_tag_o
);
	import core_cfg_pkg::*;

	logic [PREG_IDX_W-1:0] map_q [AREG_NUM];	// current mapping
	logic [PREG_NUM-1:0]   rdy_q;	// value produced

	// ==========================================================
	// lookups
	// ==========================================================
	assign opa_tag_o = map_q[ra_i];
	assign opb_tag_o = map_q[rb_i];
	assign old_tag_o = map_q[dest_i];	// freed when this rename retires

	// ready bit or a broadcast of that tag this very cycle
	assign opa_rdy_o = rdy_q[opa_tag_o] | (cdb_vld_i && (cdb_tag_i == opa_tag_o));
	assign opb_rdy_o = rdy_q[opb_tag_o] | (cdb_vld_i && (cdb_tag_i == opb_tag_o));

	// ==========================================================
	// update
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// identity map, everything committed
			for (int i = 0; i < AREG_NUM; i++) begin
				map_q[i] <= PREG_IDX_W'(i);
			end
			rdy_q <= '1;
		end else begin
			if (cdb_vld_i) begin
				rdy_q[cdb_tag_i] <= 1'b1;
			end
			// new tag came off the free list, so it cannot match the cdb tag
			if (rename_i) begin
				map_q[dest_i]    <= new_tag_i;
				rdy_q[new_tag_i] <= 1'b0;	// pending until broadcast
			end
		end
	end

	a_rename_not_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
		rename_i |-> (dest_i != AREG_IDX_W'(ZERO_REG)))
		else $error("zero register renamed");

endmodule : map_table

// File: logic/free_list.sv
// free list of physical registers
// circular queue, popped at rename, pushed with the old tag at retire
`timescale 1ns/1ps

module free_list (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 pop_i,
	input  logic                                 push_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  push_tag_i,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  free_tag_o,
	output logic                                 free_vld_o
);
	import core_cfg_pkg::*;

	logic [PREG_IDX_W-1:0] fl_q [FL_DEPTH];
	logic [FL_IDX_W-1:0]   head_q;	// next tag handed out
	logic [FL_IDX_W-1:0]   tail_q;	// next slot for a freed tag
	logic [FL_IDX_W:0]     cnt_q;

	assign free_tag_o = fl_q[head_q];
	assign free_vld_o = (cnt_q != '0);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// tags above the arch regs, in order
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_q[i] <= PREG_IDX_W'(AREG_NUM + i);
			end
			head_q <= '0;
			tail_q <= '0;	// full queue, tail wrapped onto head
			cnt_q  <= (FL_IDX_W+1)'(FL_DEPTH);
		end else begin
			if (pop_i) begin
				head_q <= head_q + 1'b1;	// depth is a power of two
			end
			if (push_i) begin
				fl_q[tail_q] <= push_tag_i;
				tail_q       <= tail_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;	// none, or one in one out
			endcase
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
		pop_i |-> free_vld_o)
		else $error("free list popped while empty");

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		(push_i && !pop_i) |-> (cnt_q != (FL_IDX_W+1)'(FL_DEPTH)))
		else $error("free list pushed while full");

endmodule : free_list

// File: logic/rob.sv
// reorder buffer
// allocation at dispatch, done marking from the cdb
// in-order retire of the head, old tag back to the free list
// halt status latched when a halt retires
`timescale 1ns/1ps

module rob (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 alloc_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  areg_i,
	input  logic                                 has_dest_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  new_tag_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  old_tag_i,
	input  logic                                 halt_i,
	input  logic                                 cdb_vld_i,
	input  logic [core_cfg_pkg::ROB_IDX_W-1:0]   cdb_rob_idx_i,
	output logic [core_cfg_pkg::ROB_IDX_W-1:0]   tail_idx_o,
	output logic                                 full_o,
	output logic                                 retire_o,
	output logic [core_cfg_pkg::AREG_IDX_W-1:0]  retire_areg_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  retire_tag_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  retire_freed_tag_o,
	output logic                                 retire_has_dest_o,
	output logic                                 halted_o,
	output core_types_pkg::core_status_e         status_o
);
	import core_cfg_pkg::*;
	import core_types_pkg::*;

	// ==========================================================
	// entry storage
	// ==========================================================
	logic [AREG_IDX_W-1:0] areg_q    [ROB_DEPTH];
	logic [PREG_IDX_W-1:0] new_tag_q [ROB_DEPTH];	// Tnew
	logic [PREG_IDX_W-1:0] old_tag_q [ROB_DEPTH];	// Told, freed at retire
	logic [ROB_DEPTH-1:0]  has_dest_q;
	logic [ROB_DEPTH-1:0]  halt_q;
	logic [ROB_DEPTH-1:0]  valid_q;
	logic [ROB_DEPTH-1:0]  done_q;

	logic [ROB_IDX_W-1:0]  head_q;	// oldest
	logic [ROB_IDX_W-1:0]  tail_q;	// next free entry
	logic [ROB_IDX_W:0]    cnt_q;
	core_status_e          status_q;
	logic                  retire;

	// head done at least one edge ago
	assign retire = valid_q[head_q] & done_q[head_q];

	assign tail_idx_o = tail_q;
	assign full_o     = (cnt_q == (ROB_IDX_W+1)'(ROB_DEPTH));

	assign retire_o           = retire;
	assign retire_areg_o      = areg_q[head_q];
	assign retire_tag_o       = new_tag_q[head_q];
	assign retire_freed_tag_o = old_tag_q[head_q];
	assign retire_has_dest_o  = has_dest_q[head_q];

	assign status_o = status_q;
	assign halted_o = (status_q == ST_HALTED);

	// payload written at allocation
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			areg_q[tail_q]     <= areg_i;
			new_tag_q[tail_q]  <= new_tag_i;
			old_tag_q[tail_q]  <= old_tag_i;
			has_dest_q[tail_q] <= has_dest_i;
			halt_q[tail_q]     <= halt_i;
		end
	end

	// ==========================================================
	// control
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q  <= '0;
			done_q   <= '0;
			head_q   <= '0;
			tail_q   <= '0;
			cnt_q    <= '0;
			status_q <= ST_NO_ERROR;
		end else begin
			if (retire) begin
				valid_q[head_q] <= 1'b0;
				head_q          <= head_q + 1'b1;
				if (halt_q[head_q]) begin
					status_q <= ST_HALTED;
				end
			end
			if (alloc_i) begin	// never while full, so tail != retiring head
				valid_q[tail_q] <= 1'b1;
				done_q[tail_q]  <= 1'b0;
				tail_q          <= tail_q + 1'b1;
			end
			if (cdb_vld_i) begin
				done_q[cdb_rob_idx_i] <= 1'b1;
			end
			case ({alloc_i, retire})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase
		end
	end

	a_cdb_hits_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
		cdb_vld_i |-> valid_q[cdb_rob_idx_i])
		else $error("completion on an empty rob entry");

endmodule : rob

// File: logic/core.sv
// core top level
// rename and retire backbone: dispatch control, map table, free list, rob
`timescale 1ns/1ps

module core (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	// decoded instruction, held while stalled
	input  logic                                 inst_vld_i,
	input  core_types_pkg::inst_class_e          inst_class_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  inst_ra_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  inst_rb_i,
	input  logic [core_cfg_pkg::AREG_IDX_W-1:0]  inst_dest_i,
	input  logic                                 inst_halt_i,
	// completion broadcast
	input  logic                                 cdb_vld_i,
	input  logic [core_cfg_pkg::PREG_IDX_W-1:0]  cdb_tag_i,
	input  logic [core_cfg_pkg::ROB_IDX_W-1:0]   cdb_rob_idx_i,
	// dispatch side
	output logic                                 dispatch_o,
	output logic                                 dispatch_stall_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  opa_tag_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  opb_tag_o,
	output logic                                 opa_rdy_o,
	output logic                                 opb_rdy_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  dest_tag_o,
	output logic [core_cfg_pkg::ROB_IDX_W-1:0]   dispatch_rob_idx_o,
	// retire side
	output logic                                 retire_o,
	output logic [core_cfg_pkg::AREG_IDX_W-1:0]  retire_areg_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  retire_tag_o,
	output logic [core_cfg_pkg::PREG_IDX_W-1:0]  retire_freed_tag_o,
	output logic                                 retire_has_dest_o,
	output core_types_pkg::core_status_e         status_o
);
	import core_cfg_pkg::*;

	logic                  dispatch_en;
	logic                  fl_pop;	// has_dest and rename strobe too
	logic                  fl_push;
	logic [PREG_IDX_W-1:0] free_tag;	// Tnew
	logic                  free_vld;
	logic [PREG_IDX_W-1:0] old_tag;	// Told
	logic                  rob_full;
	logic                  retire;
	logic                  retire_has_dest;
	logic [PREG_IDX_W-1:0] retire_freed_tag;
	logic                  halted;

	assign dispatch_o         = dispatch_en;
	assign dest_tag_o         = free_tag;
	assign retire_o           = retire;
	assign retire_has_dest_o  = retire_has_dest;
	assign retire_freed_tag_o = retire_freed_tag;
	assign fl_push            = retire & retire_has_dest;	// Told back to the pool

	dispatch_ctrl dispatch_ctrl (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_vld_i   (inst_vld_i),
		.inst_class_i (inst_class_i),
		.inst_dest_i  (inst_dest_i),
		.inst_halt_i  (inst_halt_i),
		.rob_full_i   (rob_full),
		.free_vld_i   (free_vld),
		.halted_i     (halted),
		.dispatch_o   (dispatch_en),
		.fl_pop_o     (fl_pop),
		.stall_o      (dispatch_stall_o)
	);

	map_table map_table (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ra_i      (inst_ra_i),
		.rb_i      (inst_rb_i),
		.dest_i    (inst_dest_i),
		.rename_i  (fl_pop),
		.new_tag_i (free_tag),
		.cdb_vld_i (cdb_vld_i),
		.cdb_tag_i (cdb_tag_i),
		.opa_tag_o (opa_tag_o),
		.opb_tag_o (opb_tag_o),
		.opa_rdy_o (opa_rdy_o),
		.opb_rdy_o (opb_rdy_o),
		.old_tag_o (old_tag)
	);

	free_list free_list (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.pop_i      (fl_pop),
		.push_i     (fl_push),
		.push_tag_i (retire_freed_tag),
		.free_tag_o (free_tag),
		.free_vld_o (free_vld)
	);

	rob rob (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.alloc_i            (dispatch_en),
		.areg_i             (inst_dest_i),
		.has_dest_i         (fl_pop),
		.new_tag_i          (free_tag),
		.old_tag_i          (old_tag),
		.halt_i             (inst_halt_i),
		.cdb_vld_i          (cdb_vld_i),
		.cdb_rob_idx_i      (cdb_rob_idx_i),
		.tail_idx_o         (dispatch_rob_idx_o),
		.full_o             (rob_full),
		.retire_o           (retire),
		.retire_areg_o      (retire_areg_o),
		.retire_tag_o       (retire_tag_o),
		.retire_freed_tag_o (retire_freed_tag),
		.retire_has_dest_o  (retire_has_dest),
		.halted_o           (halted),
		.status_o           (status_o)
	);

endmodule : core

// File: bench/core_tb.sv
// testbench for the rename and retire core
// reference model of map table, free list and rob order
// concurrent assertions compare the dut against the model
`timescale 1ns/1ps

module core_tb;
	import core_cfg_pkg::*;
	import core_types_pkg::*;

	localparam int TIMEOUT_CYC = 200;
	localparam int W_DISPATCH  = 0;	// wait conditions
	localparam int W_STALL     = 1;
	localparam int W_DRAINED   = 2;
	localparam int W_HALTED    = 3;

	logic                  clk;
	logic                  rst_n_i;
	logic                  inst_vld_i;
	inst_class_e           inst_class_i;
	logic [AREG_IDX_W-1:0] inst_ra_i;
	logic [AREG_IDX_W-1:0] inst_rb_i;
	logic [AREG_IDX_W-1:0] inst_dest_i;
	logic                  inst_halt_i;
	logic                  cdb_vld_i;
	logic [PREG_IDX_W-1:0] cdb_tag_i;
	logic [ROB_IDX_W-1:0]  cdb_rob_idx_i;
	logic                  dispatch_o;
	logic                  dispatch_stall_o;
	logic [PREG_IDX_W-1:0] opa_tag_o;
	logic [PREG_IDX_W-1:0] opb_tag_o;
	logic                  opa_rdy_o;
	logic                  opb_rdy_o;
	logic [PREG_IDX_W-1:0] dest_tag_o;
	logic [ROB_IDX_W-1:0]  dispatch_rob_idx_o;
	logic                  retire_o;
	logic [AREG_IDX_W-1:0] retire_areg_o;
	logic [PREG_IDX_W-1:0] retire_tag_o;
	logic [PREG_IDX_W-1:0] retire_freed_tag_o;
	logic                  retire_has_dest_o;
	core_status_e          status_o;

	int seed = 69067;
	logic [ROB_IDX_W-1:0]  pend_idx [$];	// dispatched, not yet completed
	logic [PREG_IDX_W-1:0] pend_tag [$];

	core uut (.*);

	// ==========================================================
	// reference model
	// ==========================================================
	logic [PREG_IDX_W-1:0] map_m [AREG_NUM];
	logic [PREG_NUM-1:0]   rdy_m;
	logic [PREG_IDX_W-1:0] fl_m [FL_DEPTH];	// free tags, oldest at head
	logic [FL_IDX_W-1:0]   fhead_m;
	logic [FL_IDX_W-1:0]   ftail_m;
	int                    fcnt_m;
	logic [PREG_IDX_W-1:0] rold_m [ROB_DEPTH];	// mapping before the rename
	logic [AREG_IDX_W-1:0] rareg_m [ROB_DEPTH];	// destination register
	logic [PREG_IDX_W-1:0] rtag_m [ROB_DEPTH];	// tag given at rename
	logic [ROB_DEPTH-1:0]  rhas_m;
	logic [ROB_DEPTH-1:0]  rhalt_m;
	logic [ROB_DEPTH-1:0]  rvalid_m;
	logic [ROB_DEPTH-1:0]  rdone_m;
	logic [ROB_IDX_W-1:0]  rhead_m;
	logic [ROB_IDX_W-1:0]  rtail_m;
	int                    rcnt_m;
	logic                  halt_m;	// halt already dispatched
	core_status_e          status_m;
	logic                  first_m;	// nothing dispatched since reset

	logic                  exp_needs;
	logic                  exp_block;
	logic                  exp_dispatch;
	logic                  exp_retire;
	logic [PREG_IDX_W-1:0] exp_opa_tag;
	logic [PREG_IDX_W-1:0] exp_opb_tag;
	logic [1:0]            exp_rdy;

	assign exp_needs = ((inst_class_i == CLS_ALU) || (inst_class_i == CLS_LOAD)) &&
		(inst_dest_i != AREG_IDX_W'(ZERO_REG));
	assign exp_block = (rcnt_m == ROB_DEPTH) || (exp_needs && (fcnt_m == 0)) ||
		halt_m || (status_m == ST_HALTED);
	assign exp_dispatch = inst_vld_i && !exp_block;
	assign exp_retire   = rvalid_m[rhead_m] && rdone_m[rhead_m];
	assign exp_opa_tag  = map_m[inst_ra_i];
	assign exp_opb_tag  = map_m[inst_rb_i];
	// same-cycle broadcast counts as ready
	assign exp_rdy = {rdy_m[exp_opa_tag] | (cdb_vld_i && (cdb_tag_i == exp_opa_tag)),
		rdy_m[exp_opb_tag] | (cdb_vld_i && (cdb_tag_i == exp_opb_tag))};

	always @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				map_m[i] <= PREG_IDX_W'(i);	// identity map
			end
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_m[i] <= PREG_IDX_W'(AREG_NUM + i);	// 32 .. 63
			end
			rdy_m    <= '1;
			fhead_m  <= '0;
			ftail_m  <= '0;
			fcnt_m   <= FL_DEPTH;
			rvalid_m <= '0;
			rdone_m  <= '0;
			rhead_m  <= '0;
			rtail_m  <= '0;
			rcnt_m   <= 0;
			halt_m   <= 1'b0;
			status_m <= ST_NO_ERROR;
			first_m  <= 1'b1;
		end else begin
			if (cdb_vld_i) begin
				rdy_m[cdb_tag_i]       <= 1'b1;
				rdone_m[cdb_rob_idx_i] <= 1'b1;
			end
			if (exp_retire) begin	// oldest first
				rvalid_m[rhead_m] <= 1'b0;
				rhead_m           <= rhead_m + 1'b1;
				if (rhas_m[rhead_m]) begin
					fl_m[ftail_m] <= rold_m[rhead_m];	// old mapping freed
					ftail_m       <= ftail_m + 1'b1;
				end
				if (rhalt_m[rhead_m]) begin
					status_m <= ST_HALTED;
				end
			end
			if (exp_dispatch) begin
				first_m           <= 1'b0;
				rvalid_m[rtail_m] <= 1'b1;
				rdone_m[rtail_m]  <= 1'b0;
				rold_m[rtail_m]   <= map_m[inst_dest_i];
				rareg_m[rtail_m]  <= inst_dest_i;
				rtag_m[rtail_m]   <= fl_m[fhead_m];
				rhas_m[rtail_m]   <= exp_needs;
				rhalt_m[rtail_m]  <= inst_halt_i;
				rtail_m           <= rtail_m + 1'b1;
				if (inst_halt_i) begin
					halt_m <= 1'b1;
				end
				if (exp_needs) begin
					map_m[inst_dest_i]   <= fl_m[fhead_m];
					rdy_m[fl_m[fhead_m]] <= 1'b0;	// pending until broadcast
					fhead_m              <= fhead_m + 1'b1;
				end
			end
			fcnt_m <= fcnt_m + int'(exp_retire && rhas_m[rhead_m]) -
				int'(exp_dispatch && exp_needs);
			rcnt_m <= rcnt_m + int'(exp_dispatch) - int'(exp_retire);
		end
	end

	// ==========================================================
	// checks
	// ==========================================================
	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
		abort_run();
	endtask

	a_reset_state: assert property (@(posedge clk) disable iff (!rst_n_i)
		first_m |-> ((status_o == ST_NO_ERROR) && !retire_o))
		else report_mismatch("reset_state", 0, $sampled({status_o, retire_o}));
	a_first_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(dispatch_o && first_m) |-> ({opa_rdy_o, opa_tag_o} == {1'b1, 1'b0, inst_ra_i}))
		else report_mismatch("first_read", $sampled({1'b1, 1'b0, inst_ra_i}),
			$sampled({opa_rdy_o, opa_tag_o}));
	a_dispatch: assert property (@(posedge clk) disable iff (!rst_n_i)
		dispatch_o == exp_dispatch)
		else report_mismatch("dispatch", $sampled(exp_dispatch), $sampled(dispatch_o));
	a_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		dispatch_stall_o == (inst_vld_i && exp_block))
		else report_mismatch("stall", $sampled(inst_vld_i && exp_block),
			$sampled(dispatch_stall_o));
	a_dest_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
		(exp_dispatch && exp_needs) |-> (dest_tag_o == fl_m[fhead_m]))
		else report_mismatch("dest_tag", $sampled(fl_m[fhead_m]), $sampled(dest_tag_o));
	a_rob_idx: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_dispatch |-> (dispatch_rob_idx_o == rtail_m))
		else report_mismatch("rob_idx", $sampled(rtail_m), $sampled(dispatch_rob_idx_o));
	a_src_tags: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_dispatch |-> ({opa_tag_o, opb_tag_o} == {exp_opa_tag, exp_opb_tag}))
		else report_mismatch("src_tags", $sampled({exp_opa_tag, exp_opb_tag}),
			$sampled({opa_tag_o, opb_tag_o}));
	a_src_rdy: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_dispatch |-> ({opa_rdy_o, opb_rdy_o} == exp_rdy))
		else report_mismatch("src_rdy", $sampled(exp_rdy), $sampled({opa_rdy_o, opb_rdy_o}));
	a_retire: assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_o == exp_retire)
		else report_mismatch("retire", $sampled(exp_retire), $sampled(retire_o));
	a_freed_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_retire |-> ({retire_has_dest_o, retire_freed_tag_o} ==
			{rhas_m[rhead_m], rold_m[rhead_m]}))
		else report_mismatch("freed_tag", $sampled({rhas_m[rhead_m], rold_m[rhead_m]}),
			$sampled({retire_has_dest_o, retire_freed_tag_o}));
	a_retire_dest: assert property (@(posedge clk) disable iff (!rst_n_i)
		(exp_retire && rhas_m[rhead_m]) |-> ({retire_areg_o, retire_tag_o} ==
			{rareg_m[rhead_m], rtag_m[rhead_m]}))
		else report_mismatch("retire_dest", $sampled({rareg_m[rhead_m], rtag_m[rhead_m]}),
			$sampled({retire_areg_o, retire_tag_o}));
	a_status: assert property (@(posedge clk) disable iff (!rst_n_i)
		status_o == status_m)
		else report_mismatch("status", $sampled(status_m), $sampled(status_o));

	// ==========================================================
	// stimulus helpers
	// ==========================================================
	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic cond_met(input int what);
		case (what)
			W_DISPATCH: return dispatch_o;
			W_STALL:    return dispatch_stall_o;
			W_DRAINED:  return rcnt_m == 0;
			default:    return status_o == ST_HALTED;
		endcase
	endfunction

	// sampled on the falling edge, away from the drive edge
	task automatic wait_for(input int what, input string what_name);
		int n;
		n = 0;
		@(negedge clk);
		while (!cond_met(what) && (n < TIMEOUT_CYC)) begin
			@(negedge clk);
			n++;
		end
		if (!cond_met(what)) begin
			$display("timeout: no %s within %0d cycles", what_name, TIMEOUT_CYC);
			abort_run();
		end
	endtask

	task automatic offer(input inst_class_e cls, input int ra, input int rb,
			input int dest, input logic halt);
		@(posedge clk);
		inst_vld_i   <= 1'b1;
		inst_class_i <= cls;
		inst_ra_i    <= AREG_IDX_W'(ra);
		inst_rb_i    <= AREG_IDX_W'(rb);
		inst_dest_i  <= AREG_IDX_W'(dest);
		inst_halt_i  <= halt;
	endtask

	// hold until taken, remember what to complete later
	task automatic accept();
		wait_for(W_DISPATCH, "dispatch");
		pend_idx.push_back(rtail_m);
		pend_tag.push_back(fl_m[fhead_m]);
		@(posedge clk);	// dispatch edge
		inst_vld_i  <= 1'b0;
		inst_halt_i <= 1'b0;
	endtask

	task automatic issue(input inst_class_e cls, input int ra, input int rb,
			input int dest, input logic halt);
		offer(cls, ra, rb, dest, halt);
		accept();
	endtask

	task automatic complete(input logic [ROB_IDX_W-1:0] idx,
			input logic [PREG_IDX_W-1:0] tag);
		@(posedge clk);
		cdb_vld_i     <= 1'b1;
		cdb_rob_idx_i <= idx;
		cdb_tag_i     <= tag;
		@(posedge clk);
		cdb_vld_i <= 1'b0;	// one-cycle pulse
	endtask

	// completes everything pending in a shuffled order
	task automatic complete_shuffled();
		int j;
		logic [ROB_IDX_W-1:0]  ti;
		logic [PREG_IDX_W-1:0] tt;
		for (int i = pend_idx.size() - 1; i > 0; i--) begin
			j           = rnd(i + 1);
			ti          = pend_idx[i];
			tt          = pend_tag[i];
			pend_idx[i] = pend_idx[j];
			pend_tag[i] = pend_tag[j];
			pend_idx[j] = ti;
			pend_tag[j] = tt;
		end
		while (pend_idx.size() > 0) begin
			complete(pend_idx.pop_front(), pend_tag.pop_front());
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n_i       = 1'b0;
		inst_vld_i    = 1'b0;
		inst_class_i  = CLS_ALU;
		inst_ra_i     = '0;
		inst_rb_i     = '0;
		inst_dest_i   = '0;
		inst_halt_i   = 1'b0;
		cdb_vld_i     = 1'b0;
		cdb_tag_i     = '0;
		cdb_rob_idx_i = '0;
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;

		// renaming, dependent reads, no-tag classes
		issue(CLS_ALU, 1, 2, 5, 1'b0);
		issue(CLS_ALU, 5, 5, 6, 1'b0);	// r5 still pending
		issue(CLS_STORE, 6, 5, 7, 1'b0);
		issue(CLS_BRANCH, 3, 4, 8, 1'b0);
		issue(CLS_LOAD, 7, 0, ZERO_REG, 1'b0);
		issue(CLS_LOAD, 9, 10, 6, 1'b0);	// second rename of r6
		complete_shuffled();
		wait_for(W_DRAINED, "empty rob");
		issue(CLS_ALU, 5, 6, 11, 1'b0);	// both ready now

		// enough renames to wrap past tag 63
		for (int r = 0; r < 6; r++) begin
			for (int k = 0; k < 8; k++) begin
				issue(inst_class_e'(rnd(2)), rnd(32), rnd(32), rnd(32), 1'b0);
			end
			complete_shuffled();
			wait_for(W_DRAINED, "empty rob");
		end

		// fill the rob, then free the head only
		for (int k = 0; k < ROB_DEPTH; k++) begin
			issue(CLS_ALU, rnd(32), rnd(32), rnd(31), 1'b0);
		end
		offer(CLS_ALU, 1, 2, 3, 1'b0);
		wait_for(W_STALL, "dispatch stall on a full rob");
		repeat (3) @(posedge clk);
		complete(pend_idx.pop_front(), pend_tag.pop_front());
		accept();
		complete_shuffled();
		wait_for(W_DRAINED, "empty rob");

		// halt blocks all later dispatch
		issue(CLS_ALU, 1, 2, 4, 1'b1);
		offer(CLS_ALU, 4, 4, 5, 1'b0);
		wait_for(W_STALL, "dispatch stall after halt");
		complete_shuffled();
		wait_for(W_HALTED, "halted status");
		repeat (4) @(posedge clk);
		inst_vld_i <= 1'b0;
		repeat (2) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule : core_tb

// File: list.f
logic/core_cfg_pkg.sv
logic/core_types_pkg.sv
logic/dispatch_ctrl.sv
logic/map_table.sv
logic/free_list.sv
logic/rob.sv
logic/core.sv
bench/core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
